// ==== design/vdec_settings.svh ====
// vector decode settings: instruction geometry and major opcode values
`ifndef VDEC_SETTINGS_SVH
`define VDEC_SETTINGS_SVH

// instruction word width
`define VDEC_XLEN 32

// register index width, also the width of the 5-bit immediate
`define VDEC_REG_W 5

// major opcode field width
`define VDEC_OPC_W 7

// vector arithmetic and configuration space
`define VDEC_OP_VECTOR 7'b1010111

// vector loads share the floating-point load opcode
`define VDEC_OP_LOAD_FP 7'b0000111

// vector stores share the floating-point store opcode
`define VDEC_OP_STORE_FP 7'b0100111

`endif

// ==== design/vdec_pkg.sv ====
// vector decode types: instruction views, operation enums and control bundles
`default_nettype none

`include "vdec_settings.svh"

package vdec_pkg;

  // funct3 of the vector opcode selects the operand format
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // integer OPI funct6 encodings that are decoded
  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VMSLEU = 6'b011100,
    VMSLE  = 6'b011101,
    VMSGTU = 6'b011110,
    VMSGT  = 6'b011111,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  typedef enum logic [5:0] {
    BAD_OP,
    OP_VADD, OP_VSUB, OP_VRSUB,
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA
  } vop_t;

  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfgsel_t;

  typedef enum logic [2:0] {ARITH, LOAD_UNIT, STORE_UNIT} fu_t;

  typedef enum logic [3:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR,
    VALU_SLL, VALU_SRL, VALU_SRA, VALU_COMP, VALU_MM
  } valu_op_t;

  typedef enum logic [2:0] {VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT} comp_t;

  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_t;

  // operand source: vector register, scalar register or immediate
  typedef enum logic [1:0] {V, X, I} src_t;

  // funct6 keeps the bit numbering of the instruction word
  typedef struct packed {
    logic [`VDEC_XLEN-1:`VDEC_XLEN-6] funct6;
    logic                             vm;
    logic [`VDEC_REG_W-1:0]           vs2;
    logic [`VDEC_REG_W-1:0]           vs1;
    vfunct3_t                         funct3;
    logic [`VDEC_REG_W-1:0]           vd;
    logic [`VDEC_OPC_W-1:0]           opcode;
  } varith_fmt_t;

  typedef struct packed {
    logic [2:0]             nf;
    logic                   mew;
    logic [1:0]             mop;
    logic                   vm;
    logic [`VDEC_REG_W-1:0] lumop;
    logic [`VDEC_REG_W-1:0] rs1;
    logic [2:0]             width;
    logic [`VDEC_REG_W-1:0] vd;
    logic [`VDEC_OPC_W-1:0] opcode;
  } vmem_fmt_t;

  // same word, read as arithmetic or as memory format
  typedef union packed {
    varith_fmt_t arith;
    vmem_fmt_t   mem;
  } vinstr_u;

  typedef struct packed {
    logic     is_vopi;
    logic     is_vopm;
    vfunct3_t vfunct3;
    logic     is_load;
    logic     is_store;
    logic     strided;
    cfgsel_t  cfgsel;
  } vclass_t;

  typedef struct packed {
    logic                   illegal;
    logic                   de_en;
    logic                   is_load;
    logic                   is_store;
    cfgsel_t                cfgsel;
    fu_t                    fu_type;
    valu_op_t               aluop;
    comp_t                  comp_type;
    minmax_t                minmax_type;
    logic                   is_signed;
    logic                   imm_op;
    logic                   sign_extend;
    logic                   single_bit_op;
    src_t                   rs1_type;
    src_t                   rs2_type;
    logic [`VDEC_REG_W-1:0] vd;
    logic [`VDEC_REG_W-1:0] vs1;
    logic [`VDEC_REG_W-1:0] vs2;
    logic                   vm;
    logic [`VDEC_REG_W-1:0] imm_5;
  } vctrl_t;

endpackage

`default_nettype wire

// ==== design/vdec_class_decode.sv ====
// instruction classifier: arithmetic group, memory access and config selection
`timescale 1ns/1ps
`default_nettype none

`include "vdec_settings.svh"

module vdec_class_decode (
  input  vdec_pkg::vinstr_u instr,
  output vdec_pkg::vclass_t cls
);

  // element width codes of vector loads and stores
  localparam logic [2:0] WIDTH8  = 3'b000;
  localparam logic [2:0] WIDTH16 = 3'b101;
  localparam logic [2:0] WIDTH32 = 3'b110;

  // mop code for constant-stride addressing
  localparam logic [1:0] MOP_STRIDED = 2'b10;

  vdec_pkg::vfunct3_t vfunct3;
  logic               is_vector;
  logic               is_load_op;
  logic               is_store_op;
  logic               width_ok;
  logic               is_cfg;

  assign vfunct3     = instr.arith.funct3;
  assign is_vector   = (instr.arith.opcode == `VDEC_OP_VECTOR);
  assign is_load_op  = (instr.mem.opcode == `VDEC_OP_LOAD_FP);
  assign is_store_op = (instr.mem.opcode == `VDEC_OP_STORE_FP);

  // 64-bit elements fall outside this unit
  assign width_ok = (instr.mem.width == WIDTH8) ||
                    (instr.mem.width == WIDTH16) ||
                    (instr.mem.width == WIDTH32);

  assign is_cfg = is_vector && (vfunct3 == vdec_pkg::OPCFG);

  always_comb begin
    cls = '0;
    cls.vfunct3 = vfunct3;

    cls.is_vopi = is_vector && ((vfunct3 == vdec_pkg::OPIVV) ||
                                (vfunct3 == vdec_pkg::OPIVX) ||
                                (vfunct3 == vdec_pkg::OPIVI));
    cls.is_vopm = is_vector && ((vfunct3 == vdec_pkg::OPMVV) ||
                                (vfunct3 == vdec_pkg::OPMVX));

    cls.is_load  = is_load_op && width_ok;
    cls.is_store = is_store_op && width_ok;

    // only meaningful for an accepted memory access
    cls.strided = (cls.is_load || cls.is_store) && (instr.mem.mop == MOP_STRIDED);

    // top word bits pick the config flavor
    if (!is_cfg) begin
      cls.cfgsel = vdec_pkg::NOT_CFG;
    end else if (instr.arith.funct6[`VDEC_XLEN-1] == 1'b0) begin
      cls.cfgsel = vdec_pkg::VSETVLI;
    end else if (instr.arith.funct6[`VDEC_XLEN-2] == 1'b1) begin
      cls.cfgsel = vdec_pkg::VSETIVLI;
    end else begin
      cls.cfgsel = vdec_pkg::VSETVL;
    end
  end

endmodule

`default_nettype wire

// ==== design/vdec_op_decode.sv ====
// operation decoder: maps funct6 and operand format to an op and flags illegal words
`timescale 1ns/1ps
`default_nettype none

`include "vdec_settings.svh"

module vdec_op_decode (
  input  vdec_pkg::vinstr_u instr,
  input  vdec_pkg::vclass_t cls,
  output vdec_pkg::vop_t    op,
  output logic              illegal
);

  vdec_pkg::vopi_t funct6_opi;
  logic            is_vector;
  logic            fmt_vv;
  logic            fmt_vx;
  logic            fmt_vi;
  logic            fmt_all;
  logic            fmt_vv_vx;
  logic            fmt_vx_vi;

  assign funct6_opi = vdec_pkg::vopi_t'(instr.arith.funct6);
  assign is_vector  = (instr.arith.opcode == `VDEC_OP_VECTOR);

  assign fmt_vv = (cls.vfunct3 == vdec_pkg::OPIVV);
  assign fmt_vx = (cls.vfunct3 == vdec_pkg::OPIVX);
  assign fmt_vi = (cls.vfunct3 == vdec_pkg::OPIVI);

  // legal format sets
  assign fmt_all   = fmt_vv || fmt_vx || fmt_vi;
  assign fmt_vv_vx = fmt_vv || fmt_vx;
  assign fmt_vx_vi = fmt_vx || fmt_vi;

  always_comb begin
    op = vdec_pkg::BAD_OP;
    // OPM words stay at BAD_OP
    if (cls.is_vopi) begin
      case (funct6_opi)
        vdec_pkg::VADD:   op = fmt_all   ? vdec_pkg::OP_VADD   : vdec_pkg::BAD_OP;
        vdec_pkg::VSUB:   op = fmt_vv_vx ? vdec_pkg::OP_VSUB   : vdec_pkg::BAD_OP;
        vdec_pkg::VRSUB:  op = fmt_vx_vi ? vdec_pkg::OP_VRSUB  : vdec_pkg::BAD_OP;
        vdec_pkg::VMINU:  op = fmt_vv_vx ? vdec_pkg::OP_VMINU  : vdec_pkg::BAD_OP;
        vdec_pkg::VMIN:   op = fmt_vv_vx ? vdec_pkg::OP_VMIN   : vdec_pkg::BAD_OP;
        vdec_pkg::VMAXU:  op = fmt_vv_vx ? vdec_pkg::OP_VMAXU  : vdec_pkg::BAD_OP;
        vdec_pkg::VMAX:   op = fmt_vv_vx ? vdec_pkg::OP_VMAX   : vdec_pkg::BAD_OP;
        vdec_pkg::VAND:   op = fmt_all   ? vdec_pkg::OP_VAND   : vdec_pkg::BAD_OP;
        vdec_pkg::VOR:    op = fmt_all   ? vdec_pkg::OP_VOR    : vdec_pkg::BAD_OP;
        vdec_pkg::VXOR:   op = fmt_all   ? vdec_pkg::OP_VXOR   : vdec_pkg::BAD_OP;
        vdec_pkg::VMSEQ:  op = fmt_all   ? vdec_pkg::OP_VMSEQ  : vdec_pkg::BAD_OP;
        vdec_pkg::VMSNE:  op = fmt_all   ? vdec_pkg::OP_VMSNE  : vdec_pkg::BAD_OP;
        vdec_pkg::VMSLTU: op = fmt_vv_vx ? vdec_pkg::OP_VMSLTU : vdec_pkg::BAD_OP;
        vdec_pkg::VMSLT:  op = fmt_vv_vx ? vdec_pkg::OP_VMSLT  : vdec_pkg::BAD_OP;
        vdec_pkg::VMSLEU: op = fmt_all   ? vdec_pkg::OP_VMSLEU : vdec_pkg::BAD_OP;
        vdec_pkg::VMSLE:  op = fmt_all   ? vdec_pkg::OP_VMSLE  : vdec_pkg::BAD_OP;
        // no vv form, the operands would just swap
        vdec_pkg::VMSGTU: op = fmt_vx_vi ? vdec_pkg::OP_VMSGTU : vdec_pkg::BAD_OP;
        vdec_pkg::VMSGT:  op = fmt_vx_vi ? vdec_pkg::OP_VMSGT  : vdec_pkg::BAD_OP;
        vdec_pkg::VSLL:   op = fmt_all   ? vdec_pkg::OP_VSLL   : vdec_pkg::BAD_OP;
        vdec_pkg::VSRL:   op = fmt_all   ? vdec_pkg::OP_VSRL   : vdec_pkg::BAD_OP;
        vdec_pkg::VSRA:   op = fmt_all   ? vdec_pkg::OP_VSRA   : vdec_pkg::BAD_OP;
        default:          op = vdec_pkg::BAD_OP;
      endcase
    end
  end

  // config words are legal without an op
  assign illegal = is_vector && (cls.cfgsel == vdec_pkg::NOT_CFG) &&
                   (op == vdec_pkg::BAD_OP);

endmodule

`default_nettype wire

// ==== design/vdec_ctrl_gen.sv ====
// control generator: turns class and decoded op into the execute control bundle
`timescale 1ns/1ps
`default_nettype none

`include "vdec_settings.svh"

module vdec_ctrl_gen (
  input  vdec_pkg::vinstr_u instr,
  input  vdec_pkg::vclass_t cls,
  input  vdec_pkg::vop_t    op,
  input  logic              illegal,
  output vdec_pkg::vctrl_t  ctrl
);

  vdec_pkg::valu_op_t aluop;
  vdec_pkg::comp_t    comp_type;
  vdec_pkg::minmax_t  minmax_type;
  logic               is_signed;
  logic               is_vector;
  logic               imm_op;
  logic               is_shift;
  logic               rs1_scalar;

  assign is_vector = (instr.arith.opcode == `VDEC_OP_VECTOR);

  always_comb begin
    case (op)
      vdec_pkg::OP_VADD:  aluop = vdec_pkg::VALU_ADD;
      vdec_pkg::OP_VSUB,
      vdec_pkg::OP_VRSUB: aluop = vdec_pkg::VALU_SUB;
      vdec_pkg::OP_VAND:  aluop = vdec_pkg::VALU_AND;
      vdec_pkg::OP_VOR:   aluop = vdec_pkg::VALU_OR;
      vdec_pkg::OP_VXOR:  aluop = vdec_pkg::VALU_XOR;
      vdec_pkg::OP_VSLL:  aluop = vdec_pkg::VALU_SLL;
      vdec_pkg::OP_VSRL:  aluop = vdec_pkg::VALU_SRL;
      vdec_pkg::OP_VSRA:  aluop = vdec_pkg::VALU_SRA;
      vdec_pkg::OP_VMSEQ, vdec_pkg::OP_VMSNE, vdec_pkg::OP_VMSLTU, vdec_pkg::OP_VMSLT,
      vdec_pkg::OP_VMSLEU, vdec_pkg::OP_VMSLE, vdec_pkg::OP_VMSGTU,
      vdec_pkg::OP_VMSGT: aluop = vdec_pkg::VALU_COMP;
      vdec_pkg::OP_VMINU, vdec_pkg::OP_VMIN, vdec_pkg::OP_VMAXU,
      vdec_pkg::OP_VMAX:  aluop = vdec_pkg::VALU_MM;
      default:            aluop = vdec_pkg::VALU_ADD;
    endcase
  end

  always_comb begin
    case (op)
      vdec_pkg::OP_VMSNE:  comp_type = vdec_pkg::VSNE;
      vdec_pkg::OP_VMSLTU: comp_type = vdec_pkg::VSLTU;
      vdec_pkg::OP_VMSLT:  comp_type = vdec_pkg::VSLT;
      vdec_pkg::OP_VMSLEU: comp_type = vdec_pkg::VSLEU;
      vdec_pkg::OP_VMSLE:  comp_type = vdec_pkg::VSLE;
      vdec_pkg::OP_VMSGTU: comp_type = vdec_pkg::VSGTU;
      vdec_pkg::OP_VMSGT:  comp_type = vdec_pkg::VSGT;
      default:             comp_type = vdec_pkg::VSEQ;
    endcase
  end

  always_comb begin
    case (op)
      vdec_pkg::OP_VMINU: minmax_type = vdec_pkg::MINU;
      vdec_pkg::OP_VMAX:  minmax_type = vdec_pkg::MAX;
      vdec_pkg::OP_VMAXU: minmax_type = vdec_pkg::MAXU;
      default:            minmax_type = vdec_pkg::MIN;
    endcase
  end

  // signed arithmetic and signed or equality compares
  always_comb begin
    case (op)
      vdec_pkg::OP_VADD, vdec_pkg::OP_VSUB, vdec_pkg::OP_VRSUB, vdec_pkg::OP_VMIN,
      vdec_pkg::OP_VMAX, vdec_pkg::OP_VMSEQ, vdec_pkg::OP_VMSNE, vdec_pkg::OP_VMSLT,
      vdec_pkg::OP_VMSLE, vdec_pkg::OP_VMSGT: is_signed = 1'b1;
      default:                                is_signed = 1'b0;
    endcase
  end

  assign imm_op = is_vector && ((cls.vfunct3 == vdec_pkg::OPIVI) ||
                                (cls.vfunct3 == vdec_pkg::OPCFG));

  // shift amounts and the vsetivli AVL are unsigned immediates
  assign is_shift = (op == vdec_pkg::OP_VSLL) || (op == vdec_pkg::OP_VSRL) ||
                    (op == vdec_pkg::OP_VSRA);

  assign rs1_scalar = cls.is_load || cls.is_store ||
                      (is_vector && ((cls.vfunct3 == vdec_pkg::OPIVX) ||
                                     (cls.vfunct3 == vdec_pkg::OPMVX))) ||
                      (cls.cfgsel == vdec_pkg::VSETVLI) || (cls.cfgsel == vdec_pkg::VSETVL);

  always_comb begin
    ctrl = '0;
    ctrl.illegal  = illegal;
    ctrl.de_en    = is_vector && !illegal && (cls.cfgsel == vdec_pkg::NOT_CFG);
    ctrl.is_load  = cls.is_load;
    ctrl.is_store = cls.is_store;
    ctrl.cfgsel   = cls.cfgsel;

    if (cls.is_load) begin
      ctrl.fu_type = vdec_pkg::LOAD_UNIT;
    end else if (cls.is_store) begin
      ctrl.fu_type = vdec_pkg::STORE_UNIT;
    end else begin
      ctrl.fu_type = vdec_pkg::ARITH;
    end

    ctrl.aluop         = aluop;
    ctrl.comp_type     = comp_type;
    ctrl.minmax_type   = minmax_type;
    ctrl.is_signed     = is_signed;
    ctrl.imm_op        = imm_op;
    ctrl.sign_extend   = !(is_shift || (cls.cfgsel == vdec_pkg::VSETIVLI));
    ctrl.single_bit_op = (aluop == vdec_pkg::VALU_COMP);

    if (rs1_scalar) begin
      ctrl.rs1_type = vdec_pkg::X;
    end else if (imm_op) begin
      ctrl.rs1_type = vdec_pkg::I;
    end else begin
      ctrl.rs1_type = vdec_pkg::V;
    end
    // stride comes from the second scalar register
    ctrl.rs2_type = cls.strided ? vdec_pkg::X : vdec_pkg::V;

    ctrl.vd    = instr.arith.vd;
    ctrl.vs1   = instr.arith.vs1;
    ctrl.vs2   = instr.arith.vs2;
    ctrl.vm    = instr.arith.vm;
    ctrl.imm_5 = instr.arith.vs1;
  end

endmodule

`default_nettype wire

// ==== design/vdec_top.sv ====
// vector decode stage: combinational decoders followed by one control register stage
`timescale 1ns/1ps
`default_nettype none

`include "vdec_settings.svh"

module vdec_top (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  vdec_pkg::vinstr_u instr,
  output logic              ctrl_valid,
  output vdec_pkg::vctrl_t  ctrl
);

  vdec_pkg::vclass_t cls;
  vdec_pkg::vop_t    op;
  logic              illegal;
  vdec_pkg::vctrl_t  ctrl_next;

  vdec_class_decode class_decode_i (
    .instr (instr),
    .cls   (cls)
  );

  vdec_op_decode op_decode_i (
    .instr   (instr),
    .cls     (cls),
    .op      (op),
    .illegal (illegal)
  );

  vdec_ctrl_gen ctrl_gen_i (
    .instr   (instr),
    .cls     (cls),
    .op      (op),
    .illegal (illegal),
    .ctrl    (ctrl_next)
  );

  // decode-to-execute boundary
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_valid <= 1'b0;
      ctrl       <= '0;
    end else begin
      ctrl_valid <= instr_valid;
      // hold the last bundle between strobes
      if (instr_valid) begin
        ctrl <= ctrl_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/vdec_checker.sv ====
// vector decode checker: matches each registered control bundle against its expected entry
`timescale 1ns/1ps
`default_nettype none

module vdec_checker #(
  parameter int NAME_W = 96
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ctrl_valid,
  input  vdec_pkg::vctrl_t  ctrl,
  input  logic              exp_valid,
  input  vdec_pkg::vctrl_t  exp_ctrl,
  input  logic [NAME_W-1:0] exp_name,
  input  logic              done,
  output int                pass_count,
  output int                fail_count,
  output int                outstanding
);

  // entries in flight and the cycle each was sent
  logic [NAME_W-1:0] name_q[$];
  vdec_pkg::vctrl_t  exp_q[$];
  int                sent_q[$];
  int                cycle;
  bit                reported;
  logic [NAME_W-1:0] name;
  vdec_pkg::vctrl_t  expected;
  int                sent;

  always @(posedge clk) begin
    if (!rst_n) begin
      if (ctrl_valid !== 1'b0 || ctrl !== '0) begin
        $display("Fail reset expected valid 0 ctrl %h actual valid %b ctrl %h",
                 vdec_pkg::vctrl_t'('0), ctrl_valid, ctrl);
        fail_count++;
      end
    end else begin
      cycle++;
      if (ctrl_valid) begin
        if (name_q.size() == 0) begin
          $display("ctrl_valid went high with no instruction in flight");
          fail_count++;
        end else begin
          name     = name_q.pop_front();
          expected = exp_q.pop_front();
          sent     = sent_q.pop_front();
          if (cycle - sent != 1) begin
            $display("ctrl_valid for %s came %0d cycles after its strobe instead of 1",
                     name, cycle - sent);
            fail_count++;
          end else if (ctrl === expected) begin
            $display("pass %s", name);
            pass_count++;
          end else begin
            $display("Fail %s expected %h actual %h", name, expected, ctrl);
            fail_count++;
          end
        end
      end
      // oldest entry waited too long for its ctrl_valid
      if (name_q.size() != 0 && cycle - sent_q[0] > 2) begin
        $display("no ctrl_valid within 2 cycles for %s", name_q[0]);
        fail_count++;
        name     = name_q.pop_front();
        expected = exp_q.pop_front();
        sent     = sent_q.pop_front();
      end
      if (exp_valid) begin
        name_q.push_back(exp_name);
        exp_q.push_back(exp_ctrl);
        sent_q.push_back(cycle);
      end
      outstanding = name_q.size();
      if (done && !reported) begin
        $display("checks done: %0d passed, %0d failed", pass_count, fail_count);
        reported = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/vdec_tb.sv ====
// vector decode testbench: clock, reset and a table of instructions with expected control
`timescale 1ns/1ps
`default_nettype none

module vdec_tb;

  localparam int NAME_W = 96;

  // funct3 formats and major opcodes as the vector spec encodes them
  localparam logic [2:0] IVV = 3'b000;
  localparam logic [2:0] MVV = 3'b010;
  localparam logic [2:0] IVI = 3'b011;
  localparam logic [2:0] IVX = 3'b100;
  localparam logic [2:0] MVX = 3'b110;
  localparam logic [2:0] CFG = 3'b111;
  localparam logic [6:0] OPC_V  = 7'b1010111;
  localparam logic [6:0] OPC_LD = 7'b0000111;
  localparam logic [6:0] OPC_ST = 7'b0100111;

  logic              clk;
  logic              rst_n;
  logic              instr_valid;
  vdec_pkg::vinstr_u instr;
  logic              ctrl_valid;
  vdec_pkg::vctrl_t  ctrl;
  logic              exp_valid;
  vdec_pkg::vctrl_t  exp_ctrl;
  logic [NAME_W-1:0] exp_name;
  logic              done;
  int                pass_count;
  int                fail_count;
  int                outstanding;

  integer            seed = 32'ha690_7752;
  logic [4:0]        rd;
  logic [4:0]        r1;
  logic [4:0]        r2;
  logic              vmb;

  logic [NAME_W-1:0] name_q[$];
  vdec_pkg::vinstr_u word_q[$];
  vdec_pkg::vctrl_t  exp_q[$];

  vdec_top vdec_top_i (
    .CLK         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ctrl_valid  (ctrl_valid),
    .ctrl        (ctrl)
  );

  vdec_checker #(.NAME_W(NAME_W)) check_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl_valid  (ctrl_valid),
    .ctrl        (ctrl),
    .exp_valid   (exp_valid),
    .exp_ctrl    (exp_ctrl),
    .exp_name    (exp_name),
    .done        (done),
    .pass_count  (pass_count),
    .fail_count  (fail_count),
    .outstanding (outstanding)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // new register fields for the rows that follow
  task automatic roll(input logic zero_vs2);
    logic [31:0] r;
    r   = $random(seed);
    rd  = r[4:0];
    r1  = r[9:5];
    r2  = zero_vs2 ? 5'd0 : r[14:10];
    vmb = r[15];
  endtask

  function automatic vdec_pkg::vinstr_u vw(input logic [5:0] f6, input logic [2:0] f3);
    return {f6, vmb, r2, r1, f3, rd, OPC_V};
  endfunction

  function automatic vdec_pkg::vinstr_u mw(input logic [6:0] opc, input logic [1:0] mop,
                                           input logic [2:0] width);
    return {3'b000, 1'b0, mop, vmb, r2, r1, width, rd, opc};
  endfunction

  // register fields always come from the arithmetic view
  function automatic vdec_pkg::vctrl_t base_exp(input vdec_pkg::src_t rs1);
    vdec_pkg::vctrl_t e;
    e             = '0;
    e.rs1_type    = rs1;
    e.imm_op      = (rs1 == vdec_pkg::I);
    e.sign_extend = 1'b1;
    e.vd          = rd;
    e.vs1         = r1;
    e.imm_5       = r1;
    e.vs2         = r2;
    e.vm          = vmb;
    return e;
  endfunction

  function automatic vdec_pkg::vctrl_t alu_exp(input vdec_pkg::valu_op_t op, input logic sgn,
                                               input vdec_pkg::src_t rs1);
    vdec_pkg::vctrl_t e;
    e               = base_exp(rs1);
    e.de_en         = 1'b1;
    e.aluop         = op;
    e.is_signed     = sgn;
    // shift amounts are zero-extended
    e.sign_extend   = !((op == vdec_pkg::VALU_SLL) || (op == vdec_pkg::VALU_SRL) ||
                        (op == vdec_pkg::VALU_SRA));
    return e;
  endfunction

  // compares write one mask bit per element
  function automatic vdec_pkg::vctrl_t cmp_exp(input vdec_pkg::comp_t c, input logic sgn,
                                               input vdec_pkg::src_t rs1);
    vdec_pkg::vctrl_t e;
    e               = alu_exp(vdec_pkg::VALU_COMP, sgn, rs1);
    e.comp_type     = c;
    e.single_bit_op = 1'b1;
    return e;
  endfunction

  function automatic vdec_pkg::vctrl_t mm_exp(input vdec_pkg::minmax_t m, input logic sgn,
                                              input vdec_pkg::src_t rs1);
    vdec_pkg::vctrl_t e;
    e             = alu_exp(vdec_pkg::VALU_MM, sgn, rs1);
    e.minmax_type = m;
    return e;
  endfunction

  function automatic vdec_pkg::vctrl_t bad_exp(input vdec_pkg::src_t rs1);
    vdec_pkg::vctrl_t e;
    e         = base_exp(rs1);
    e.illegal = 1'b1;
    return e;
  endfunction

  function automatic vdec_pkg::vctrl_t mem_exp(input logic load, input logic strided);
    vdec_pkg::vctrl_t e;
    e          = base_exp(vdec_pkg::X);
    e.is_load  = load;
    e.is_store = !load;
    e.fu_type  = load ? vdec_pkg::LOAD_UNIT : vdec_pkg::STORE_UNIT;
    e.rs2_type = strided ? vdec_pkg::X : vdec_pkg::V;
    return e;
  endfunction

  function automatic vdec_pkg::vctrl_t cfg_exp(input vdec_pkg::cfgsel_t sel,
                                               input vdec_pkg::src_t rs1);
    vdec_pkg::vctrl_t e;
    e             = base_exp(rs1);
    e.imm_op      = 1'b1;
    e.cfgsel      = sel;
    e.sign_extend = (sel != vdec_pkg::VSETIVLI);
    return e;
  endfunction

  task automatic add_row(input logic [NAME_W-1:0] nm, input vdec_pkg::vinstr_u w,
                         input vdec_pkg::vctrl_t e);
    name_q.push_back(nm);
    word_q.push_back(w);
    exp_q.push_back(e);
  endtask

  task automatic build_table;
    roll(1'b0);
    add_row("vadd.vv", vw(6'b000000, IVV), alu_exp(vdec_pkg::VALU_ADD, 1'b1, vdec_pkg::V));
    add_row("vsub.vx", vw(6'b000010, IVX), alu_exp(vdec_pkg::VALU_SUB, 1'b1, vdec_pkg::X));
    add_row("vand.vi", vw(6'b001001, IVI), alu_exp(vdec_pkg::VALU_AND, 1'b0, vdec_pkg::I));
    add_row("vsll.vi", vw(6'b100101, IVI), alu_exp(vdec_pkg::VALU_SLL, 1'b0, vdec_pkg::I));
    add_row("vsra.vv", vw(6'b101001, IVV), alu_exp(vdec_pkg::VALU_SRA, 1'b0, vdec_pkg::V));
    roll(1'b0);
    add_row("vmseq.vv", vw(6'b011000, IVV), cmp_exp(vdec_pkg::VSEQ, 1'b1, vdec_pkg::V));
    add_row("vmsne.vx", vw(6'b011001, IVX), cmp_exp(vdec_pkg::VSNE, 1'b1, vdec_pkg::X));
    add_row("vmsltu.vv", vw(6'b011010, IVV), cmp_exp(vdec_pkg::VSLTU, 1'b0, vdec_pkg::V));
    add_row("vmslt.vx", vw(6'b011011, IVX), cmp_exp(vdec_pkg::VSLT, 1'b1, vdec_pkg::X));
    add_row("vmsleu.vi", vw(6'b011100, IVI), cmp_exp(vdec_pkg::VSLEU, 1'b0, vdec_pkg::I));
    add_row("vmsle.vv", vw(6'b011101, IVV), cmp_exp(vdec_pkg::VSLE, 1'b1, vdec_pkg::V));
    add_row("vmsgtu.vx", vw(6'b011110, IVX), cmp_exp(vdec_pkg::VSGTU, 1'b0, vdec_pkg::X));
    add_row("vmsgt.vi", vw(6'b011111, IVI), cmp_exp(vdec_pkg::VSGT, 1'b1, vdec_pkg::I));
    add_row("vminu.vv", vw(6'b000100, IVV), mm_exp(vdec_pkg::MINU, 1'b0, vdec_pkg::V));
    add_row("vmax.vx", vw(6'b000111, IVX), mm_exp(vdec_pkg::MAX, 1'b1, vdec_pkg::X));
    roll(1'b0);
    add_row("vsub.vi", vw(6'b000010, IVI), bad_exp(vdec_pkg::I));
    add_row("vmin.vi", vw(6'b000101, IVI), bad_exp(vdec_pkg::I));
    add_row("vrsub.vv", vw(6'b000011, IVV), bad_exp(vdec_pkg::V));
    add_row("opm.vv", vw(6'b100101, MVV), bad_exp(vdec_pkg::V));
    add_row("opm.vx", vw(6'b100101, MVX), bad_exp(vdec_pkg::X));
    add_row("bad.funct6", vw(6'b111111, IVV), bad_exp(vdec_pkg::V));
    // unit stride needs a zero lumop
    roll(1'b1);
    add_row("vle8", mw(OPC_LD, 2'b00, 3'b000), mem_exp(1'b1, 1'b0));
    add_row("vle32", mw(OPC_LD, 2'b00, 3'b110), mem_exp(1'b1, 1'b0));
    add_row("vse16", mw(OPC_ST, 2'b00, 3'b101), mem_exp(1'b0, 1'b0));
    add_row("vle64", mw(OPC_LD, 2'b00, 3'b111), base_exp(vdec_pkg::V));
    roll(1'b0);
    add_row("vlse16", mw(OPC_LD, 2'b10, 3'b101), mem_exp(1'b1, 1'b1));
    add_row("vsse8", mw(OPC_ST, 2'b10, 3'b000), mem_exp(1'b0, 1'b1));
    add_row("vsse32", mw(OPC_ST, 2'b10, 3'b110), mem_exp(1'b0, 1'b1));
    roll(1'b0);
    add_row("vsetvli", vw({1'b0, r2}, CFG), cfg_exp(vdec_pkg::VSETVLI, vdec_pkg::X));
    add_row("vsetivli", vw({2'b11, r2[3:0]}, CFG), cfg_exp(vdec_pkg::VSETIVLI, vdec_pkg::I));
    add_row("vsetvl", vw(6'b100000, CFG), cfg_exp(vdec_pkg::VSETVL, vdec_pkg::X));
  endtask

  initial begin
    int   waits;
    logic drained;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_valid   = 1'b0;
    exp_ctrl    = '0;
    exp_name    = '0;
    done        = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // a few quiet cycles so a stray ctrl_valid shows up
    repeat (2) @(posedge clk);

    for (int i = 0; i < word_q.size(); i++) begin
      @(posedge clk);
      #1;
      instr       = word_q[i];
      instr_valid = 1'b1;
      exp_ctrl    = exp_q[i];
      exp_name    = name_q[i];
      exp_valid   = 1'b1;
      // idle cycle after every fifth entry
      if (i % 5 == 4) begin
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        exp_valid   = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    exp_valid   = 1'b0;

    waits = 0;
    while (outstanding != 0 && waits < 5) begin
      @(posedge clk);
      #1;
      waits++;
    end
    drained = (outstanding == 0);
    if (!drained) begin
      $display("timed out waiting for the last results to come back");
    end
    done = 1'b1;
    @(posedge clk);
    #1;
    if (!drained || fail_count != 0 || pass_count != word_q.size()) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/vdec_pkg.sv
design/vdec_class_decode.sv
design/vdec_op_decode.sv
design/vdec_ctrl_gen.sv
design/vdec_top.sv
test/vdec_checker.sv
test/vdec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= vdec_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# the log decides the result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
